// File: hw/centipede_io_pkg.sv
// shared definitions for the centipede i/o section
// bus byte and address, decoded regions, led and coin drives
// and the trackball axis constants
package centipede_io_pkg;

   // one byte on the processor data bus
   typedef logic [7:0] io_byte_t;

   // processor address
   // bits 13 to 10 pick the i/o region
   typedef logic [13:0] bus_addr_t;

   // decoded i/o regions, encoded as the value of address bits 13:10
   // anything not kept here decodes to RGN_NONE
   typedef enum logic [3:0] {
      RGN_SWITCH   = 4'd2,
      RGN_INPUT    = 4'd3,
      RGN_OUT0     = 4'd7,
      RGN_STEERCLR = 4'd9,
      RGN_NONE     = 4'd15
   } io_region_e;

   // led drives, led 3 in the msb
   typedef logic [3:0] led_t;

   // coin counter drives
   // bit 2 right, bit 1 center, bit 0 left
   typedef logic [2:0] coin_ctr_t;

   // trackball axes, horizontal first
   localparam int NUM_AXES = 2;
   localparam int AXIS_H   = 0;
   localparam int AXIS_V   = 1;

   // default steering counter width
   localparam int TB_CTR_WIDTH = 4;

   // counter field as it appears in the read byte
   typedef logic [TB_CTR_WIDTH-1:0] tb_ctr_t;

   // raw trackball lines
   // 7 p1 h dir, 6 p2 h dir, 5 p1 h clk, 4 p2 h clk
   // 3 p1 v dir, 2 p2 v dir, 1 p1 v clk, 0 p2 v clk
   typedef logic [7:0] tb_raw_t;

endpackage

// File: hw/mpu_io_control.sv
// processor side of the i/o section
// decodes the region, holds the addressable output latch,
// the read selection and the steering clear strobe
module mpu_io_control
(
   input  logic                         reset_i,
   input  logic                         s_6mhz_i,
   input  centipede_io_pkg::bus_addr_t  bus_addr_i,
   input  centipede_io_pkg::io_byte_t   bus_data_i,
   input  logic                         bus_wr_i,
   input  logic                         bus_rd_i,
   output centipede_io_pkg::io_region_e rd_region_o,
   output logic [1:0]                   rd_sel_o,
   output logic                         steer_clr_o,
   output logic                         flip_o,
   output centipede_io_pkg::led_t       led_o,
   output centipede_io_pkg::coin_ctr_t  coin_ctr_o
);
   import centipede_io_pkg::*;

   io_region_e addr_region;
   io_region_e rd_region_q;
   logic [1:0] rd_sel_q;
   io_byte_t   out_latch;
   logic       out0_wr;
   logic       steer_wr;

   // region select from the top four address bits
   always_comb
   begin
      case (bus_addr_i[13:10])
         4'd2:    addr_region = RGN_SWITCH;
         4'd3:    addr_region = RGN_INPUT;
         4'd7:    addr_region = RGN_OUT0;
         4'd9:    addr_region = RGN_STEERCLR;
         default: addr_region = RGN_NONE;
      endcase
   end

   assign out0_wr  = bus_wr_i && (addr_region == RGN_OUT0);
   assign steer_wr = bus_wr_i && (addr_region == RGN_STEERCLR);

   // addressable latch
   // address bits 2:0 pick the bit, data bit 7 is the value
   always_ff @(posedge s_6mhz_i or posedge reset_i)
   begin
      if (reset_i)
         out_latch <= '0;
      else if (out0_wr)
         out_latch[bus_addr_i[2:0]] <= bus_data_i[7];
   end

   // one cycle clear pulse after a steering clear write
   always_ff @(posedge s_6mhz_i or posedge reset_i)
   begin
      if (reset_i)
         steer_clr_o <= 1'b0;
      else
         steer_clr_o <= steer_wr;
   end

   // remember region and low bits of the last read
   always_ff @(posedge s_6mhz_i or posedge reset_i)
   begin
      if (reset_i)
      begin
         rd_region_q <= RGN_NONE;
         rd_sel_q    <= 2'b00;
      end
      else if (bus_rd_i)
      begin
         rd_region_q <= addr_region;
         rd_sel_q    <= bus_addr_i[1:0];
      end
   end

   // current read goes straight through so the byte lands one cycle later
   // otherwise the held selection keeps the read mux on the same source
   assign rd_region_o = bus_rd_i ? addr_region : rd_region_q;
   assign rd_sel_o    = bus_rd_i ? bus_addr_i[1:0] : rd_sel_q;

   // latch bit map
   assign flip_o     = out_latch[7];
   assign led_o      = out_latch[6:3];
   assign coin_ctr_o = out_latch[2:0];

endmodule

// File: hw/trakball_sync.sv
// brings the raw trackball lines into the s_6mhz domain
// and picks the player feeding each axis from the flip bit
module trakball_sync
(
   input  logic                                  reset_i,
   input  logic                                  s_6mhz_i,
   input  centipede_io_pkg::tb_raw_t             trakball_i,
   input  logic                                  flip_i,
   output logic [centipede_io_pkg::NUM_AXES-1:0] ck_sync_o,
   output logic [centipede_io_pkg::NUM_AXES-1:0] dir_sync_o
);
   import centipede_io_pkg::*;

   tb_raw_t raw_meta;
   tb_raw_t raw_sync;

   // two flops on every line
   always_ff @(posedge s_6mhz_i or posedge reset_i)
   begin
      if (reset_i)
      begin
         raw_meta <= '0;
         raw_sync <= '0;
      end
      else
      begin
         raw_meta <= trakball_i;
         raw_sync <= raw_meta;
      end
   end

   // flip set means player 1 is at the controls
   always_comb
   begin
      if (flip_i)
      begin
         dir_sync_o[AXIS_H] = raw_sync[7];
         ck_sync_o[AXIS_H]  = raw_sync[5];
         dir_sync_o[AXIS_V] = raw_sync[3];
         ck_sync_o[AXIS_V]  = raw_sync[1];
      end
      else
      begin
         dir_sync_o[AXIS_H] = raw_sync[6];
         ck_sync_o[AXIS_H]  = raw_sync[4];
         dir_sync_o[AXIS_V] = raw_sync[2];
         ck_sync_o[AXIS_V]  = raw_sync[0];
      end
   end

endmodule

// File: hw/trakball_axis.sv
// one trackball steering axis
// counts synchronized clock edges up or down by the direction
// seen on the previous edge
module trakball_axis
#(
   parameter int ctr_width = centipede_io_pkg::TB_CTR_WIDTH
)
(
   input  logic                 reset_i,
   input  logic                 s_6mhz_i,
   input  logic                 ck_i,
   input  logic                 dir_i,
   input  logic                 clr_i,
   output logic [ctr_width-1:0] ctr_o,
   output logic                 dir_o
);

   logic                 ck_q;
   logic                 ck_rise;
   logic                 dir_q;
   logic [ctr_width-1:0] ctr_q;

   // rising edge of the synchronized clock
   assign ck_rise = ck_i & ~ck_q;

   always_ff @(posedge s_6mhz_i or posedge reset_i)
   begin
      if (reset_i)
      begin
         ck_q  <= 1'b0;
         dir_q <= 1'b0;
      end
      else
      begin
         ck_q <= ck_i;
         // direction captured on each edge
         if (ck_rise)
            dir_q <= dir_i;
      end
   end

   // counter steps by the old direction and wraps
   // steering clear wins over a count in the same cycle
   always_ff @(posedge s_6mhz_i or posedge reset_i)
   begin
      if (reset_i)
         ctr_q <= '0;
      else if (clr_i)
         ctr_q <= '0;
      else if (ck_rise)
      begin
         if (dir_q)
            ctr_q <= ctr_q + 1'b1;
         else
            ctr_q <= ctr_q - 1'b1;
      end
   end

   assign ctr_o = ctr_q;
   assign dir_o = dir_q;

endmodule

// File: hw/io_read_mux.sv
// read data path of the i/o section
// builds the byte for switches, player inputs, trackball and joystick
// and registers it for the processor
module io_read_mux
#(
   parameter int ctr_width = centipede_io_pkg::TB_CTR_WIDTH
)
(
   input  logic                         reset_i,
   input  logic                         s_6mhz_i,
   input  centipede_io_pkg::io_region_e rd_region_i,
   input  logic [1:0]                   rd_sel_i,
   input  logic [ctr_width-1:0]         ctr_h_i,
   input  logic [ctr_width-1:0]         ctr_v_i,
   input  logic                         dir_h_i,
   input  logic                         dir_v_i,
   input  logic [9:0]                   player_input_i,
   input  centipede_io_pkg::coin_ctr_t  coin_ctr_i,
   input  centipede_io_pkg::io_byte_t   joystick_i,
   input  centipede_io_pkg::io_byte_t   sw1_i,
   input  centipede_io_pkg::io_byte_t   sw2_i,
   input  logic                         vblank_i,
   output centipede_io_pkg::io_byte_t   rd_data_o
);
   import centipede_io_pkg::*;

   tb_ctr_t   ctr_h_fld;
   tb_ctr_t   ctr_v_fld;
   coin_ctr_t coin_seen;
   io_byte_t  rd_next;

   // counters fitted to the nibble of the read byte
   assign ctr_h_fld = tb_ctr_t'(ctr_h_i);
   assign ctr_v_fld = tb_ctr_t'(ctr_v_i);

   // a driven coin counter reads back as a coin
   assign coin_seen = player_input_i[9:7] | coin_ctr_i;

   always_comb
   begin
      rd_next = '0;
      case (rd_region_i)
         RGN_SWITCH:
            rd_next = rd_sel_i[0] ? sw2_i : sw1_i;
         RGN_INPUT:
         begin
            case (rd_sel_i)
               // h dir, vblank, self test, cocktail, h count
               2'b00: rd_next = {dir_h_i, vblank_i, player_input_i[6:5], ctr_h_fld};
               // coins r c l, slam, fire2, fire1, start1, start2
               2'b01: rd_next = {coin_seen, player_input_i[4], player_input_i[1],
                                 player_input_i[0], player_input_i[3], player_input_i[2]};
               2'b10: rd_next = {dir_v_i, 3'b000, ctr_v_fld};
               default: rd_next = joystick_i;
            endcase
         end
         // unkept regions read as zero
         default:
            rd_next = '0;
      endcase
   end

   always_ff @(posedge s_6mhz_i or posedge reset_i)
   begin
      if (reset_i)
         rd_data_o <= '0;
      else
         rd_data_o <= rd_next;
   end

endmodule

// File: hw/centipede_io.sv
// centipede processor i/o section
// output latch, trackball steering and read data for a 6 mhz bus
module centipede_io
#(
   parameter int ctr_width = centipede_io_pkg::TB_CTR_WIDTH
)
(
   input  logic                        reset,
   input  logic                        s_6mhz,
   input  centipede_io_pkg::bus_addr_t bus_addr_i,
   input  centipede_io_pkg::io_byte_t  bus_data_i,
   input  logic                        bus_wr_i,
   input  logic                        bus_rd_i,
   input  logic [9:0]                  player_input_i,
   input  centipede_io_pkg::tb_raw_t   trakball_i,
   input  centipede_io_pkg::io_byte_t  joystick_i,
   input  centipede_io_pkg::io_byte_t  sw1_i,
   input  centipede_io_pkg::io_byte_t  sw2_i,
   input  logic                        vblank_i,
   output centipede_io_pkg::io_byte_t  rd_data_o,
   output centipede_io_pkg::led_t      led_o,
   output centipede_io_pkg::coin_ctr_t coin_ctr_o
);
   import centipede_io_pkg::*;

   io_region_e           rd_region;
   logic [1:0]           rd_sel;
   logic                 steer_clr;
   logic                 flip;
   logic [NUM_AXES-1:0]  ck_sync;
   logic [NUM_AXES-1:0]  dir_sync;
   logic [NUM_AXES-1:0]  dir;
   logic [ctr_width-1:0] ctr [NUM_AXES];

   mpu_io_control ctrl_i (
      .reset_i     (reset),
      .s_6mhz_i    (s_6mhz),
      .bus_addr_i  (bus_addr_i),
      .bus_data_i  (bus_data_i),
      .bus_wr_i    (bus_wr_i),
      .bus_rd_i    (bus_rd_i),
      .rd_region_o (rd_region),
      .rd_sel_o    (rd_sel),
      .steer_clr_o (steer_clr),
      .flip_o      (flip),
      .led_o       (led_o),
      .coin_ctr_o  (coin_ctr_o)
   );

   trakball_sync sync_i (
      .reset_i    (reset),
      .s_6mhz_i   (s_6mhz),
      .trakball_i (trakball_i),
      .flip_i     (flip),
      .ck_sync_o  (ck_sync),
      .dir_sync_o (dir_sync)
   );

   // one counter per axis, both cleared by the same strobe
   for (genvar a = 0; a < NUM_AXES; a++)
   begin : g_axis
      trakball_axis #(.ctr_width(ctr_width)) axis_i (
         .reset_i  (reset),
         .s_6mhz_i (s_6mhz),
         .ck_i     (ck_sync[a]),
         .dir_i    (dir_sync[a]),
         .clr_i    (steer_clr),
         .ctr_o    (ctr[a]),
         .dir_o    (dir[a])
      );
   end

   io_read_mux #(.ctr_width(ctr_width)) rmux_i (
      .reset_i        (reset),
      .s_6mhz_i       (s_6mhz),
      .rd_region_i    (rd_region),
      .rd_sel_i       (rd_sel),
      .ctr_h_i        (ctr[AXIS_H]),
      .ctr_v_i        (ctr[AXIS_V]),
      .dir_h_i        (dir[AXIS_H]),
      .dir_v_i        (dir[AXIS_V]),
      .player_input_i (player_input_i),
      .coin_ctr_i     (coin_ctr_o),
      .joystick_i     (joystick_i),
      .sw1_i          (sw1_i),
      .sw2_i          (sw2_i),
      .vblank_i       (vblank_i),
      .rd_data_o      (rd_data_o)
   );

endmodule

// File: verification/tb_centipede_io.sv
// testbench for the centipede i/o section
// replays the command file against the dut and checks
// read data, led and coin counter outputs
module tb_centipede_io;
   timeunit 1ns;
   timeprecision 100ps;

   import centipede_io_pkg::*;

   localparam int    CLK_PERIOD = 100;
   localparam string STIM_FILE  = "verification/centipede_io_stim.txt";

   // command letters of the stimulus file
   typedef enum logic [7:0] {
      OP_NOTE   = 8'h23,
      OP_PLAYER = 8'h50,
      OP_READ   = 8'h52,
      OP_TRACK  = 8'h54,
      OP_WRITE  = 8'h57,
      OP_LEDS   = 8'h4c,
      OP_END    = 8'h45
   } stim_op_e;

   logic       s_6mhz = 1'b0;
   logic       reset;
   bus_addr_t  bus_addr;
   io_byte_t   bus_data;
   logic       bus_wr;
   logic       bus_rd;
   logic [9:0] player_input;
   tb_raw_t    trakball;
   io_byte_t   joystick;
   io_byte_t   sw1;
   io_byte_t   sw2;
   logic       vblank;
   io_byte_t   rd_data;
   led_t       led;
   coin_ctr_t  coin_ctr;

   int seed       = 28003;
   int err_cnt    = 0;
   int stim_lines = 0;

   centipede_io #(.ctr_width(TB_CTR_WIDTH)) dut_i (
      .reset          (reset),
      .s_6mhz         (s_6mhz),
      .bus_addr_i     (bus_addr),
      .bus_data_i     (bus_data),
      .bus_wr_i       (bus_wr),
      .bus_rd_i       (bus_rd),
      .player_input_i (player_input),
      .trakball_i     (trakball),
      .joystick_i     (joystick),
      .sw1_i          (sw1),
      .sw2_i          (sw2),
      .vblank_i       (vblank),
      .rd_data_o      (rd_data),
      .led_o          (led),
      .coin_ctr_o     (coin_ctr)
   );

   always #(CLK_PERIOD / 2) s_6mhz = ~s_6mhz;

   task automatic abort_run();
      err_cnt++;
      $display("sim failed");
      $fatal(1, "testbench stopped on error");
   endtask

   task automatic check_byte(input string name, input io_byte_t got, input io_byte_t exp_val);
      if (got !== exp_val)
      begin
         $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp_val);
         abort_run();
      end
   endtask

   task automatic check_led(input string name, input led_t got, input led_t exp_val);
      if (got !== exp_val)
      begin
         $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp_val);
         abort_run();
      end
   endtask

   task automatic check_coin(input string name, input coin_ctr_t got, input coin_ctr_t exp_val);
      if (got !== exp_val)
      begin
         $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp_val);
         abort_run();
      end
   endtask

   task automatic require_fields(input int got, input int want);
      if (got != want)
      begin
         $display("malformed stimulus line, %0d of %0d fields read", got, want);
         abort_run();
      end
   endtask

   // newline count of the command file sizes the watchdog
   task automatic count_stim_lines(output int lines);
      int fd;
      int c;
      lines = 0;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0)
      begin
         $display("cannot open stimulus file %s", STIM_FILE);
         abort_run();
      end
      else
      begin
         c = $fgetc(fd);
         while (c != -1)
         begin
            if (c == 10)
               lines++;
            c = $fgetc(fd);
         end
         $fclose(fd);
      end
   endtask

   // first character past blanks and line ends
   function automatic int next_nonblank(input int fd);
      int c;
      c = $fgetc(fd);
      while (c == 32 || c == 9 || c == 10 || c == 13)
         c = $fgetc(fd);
      return c;
   endfunction

   task automatic skip_line(input int fd);
      int c;
      c = $fgetc(fd);
      while (c != 10 && c != -1)
         c = $fgetc(fd);
   endtask

   // one cycle write strobe
   // address bits 9:3 and data bits 6:0 are ignored by the latch
   task automatic bus_write(input bus_addr_t addr, input io_byte_t data);
      logic [31:0] rnd;
      rnd = $random(seed);
      @(posedge s_6mhz);
      bus_addr <= {addr[13:10], rnd[9:3], addr[2:0]};
      bus_data <= {data[7], rnd[6:0]};
      bus_wr   <= 1'b1;
      @(posedge s_6mhz);
      bus_wr <= 1'b0;
   endtask

   // read byte is registered at the edge that sees the strobe
   task automatic bus_read(input bus_addr_t addr, input io_byte_t exp_byte);
      logic [31:0] rnd;
      rnd = $random(seed);
      @(posedge s_6mhz);
      bus_addr <= {addr[13:10], rnd[7:0], addr[1:0]};
      bus_rd   <= 1'b1;
      @(posedge s_6mhz);
      bus_rd <= 1'b0;
      @(negedge s_6mhz);
      check_byte("rd_data_o", rd_data, exp_byte);
   endtask

   // 2 sync flops and the edge detect fit well inside 5 clocks
   task automatic track_step(input tb_raw_t raw_val);
      @(posedge s_6mhz);
      trakball <= raw_val;
      repeat (5) @(posedge s_6mhz);
   endtask

   initial
   begin
      int         fd;
      int         c;
      int         n;
      bit         done;
      bus_addr_t  addr_val;
      io_byte_t   byte_val;
      io_byte_t   joy_val;
      io_byte_t   sw1_val;
      io_byte_t   sw2_val;
      logic [9:0] player_val;
      logic       vblank_val;
      tb_raw_t    raw_val;
      led_t       led_val;
      coin_ctr_t  coin_val;

      reset        <= 1'b1;
      bus_addr     <= '0;
      bus_data     <= '0;
      bus_wr       <= 1'b0;
      bus_rd       <= 1'b0;
      player_input <= '0;
      trakball     <= '0;
      joystick     <= '0;
      sw1          <= '0;
      sw2          <= '0;
      vblank       <= 1'b0;

      count_stim_lines(stim_lines);
      repeat (8) @(posedge s_6mhz);
      reset <= 1'b0;

      // outputs come out of reset cleared
      @(negedge s_6mhz);
      check_byte("rd_data_o", rd_data, '0);
      check_led("led_o", led, '0);
      check_coin("coin_ctr_o", coin_ctr, '0);

      fd = $fopen(STIM_FILE, "r");
      done = 1'b0;
      while (!done)
      begin
         c = next_nonblank(fd);
         if (c == -1)
         begin
            $display("stimulus file ends without an end command");
            abort_run();
         end
         else
         begin
            case (stim_op_e'(c[7:0]))
               OP_NOTE:
                  skip_line(fd);
               OP_WRITE:
               begin
                  n = $fscanf(fd, "%h %h", addr_val, byte_val);
                  require_fields(n, 2);
                  bus_write(addr_val, byte_val);
               end
               OP_READ:
               begin
                  n = $fscanf(fd, "%h %h", addr_val, byte_val);
                  require_fields(n, 2);
                  bus_read(addr_val, byte_val);
               end
               OP_TRACK:
               begin
                  n = $fscanf(fd, "%h", raw_val);
                  require_fields(n, 1);
                  track_step(raw_val);
               end
               OP_PLAYER:
               begin
                  n = $fscanf(fd, "%h %h %h %h %h", player_val, joy_val, sw1_val,
                              sw2_val, vblank_val);
                  require_fields(n, 5);
                  @(posedge s_6mhz);
                  player_input <= player_val;
                  joystick     <= joy_val;
                  sw1          <= sw1_val;
                  sw2          <= sw2_val;
                  vblank       <= vblank_val;
               end
               OP_LEDS:
               begin
                  n = $fscanf(fd, "%h %h", led_val, coin_val);
                  require_fields(n, 2);
                  @(negedge s_6mhz);
                  check_led("led_o", led, led_val);
                  check_coin("coin_ctr_o", coin_ctr, coin_val);
               end
               OP_END:
                  done = 1'b1;
               default:
               begin
                  $display("unknown stimulus opcode %c", c[7:0]);
                  abort_run();
               end
            endcase
         end
      end
      $fclose(fd);

      if (err_cnt == 0)
      begin
         $display("sim passed");
         $finish;
      end
      else
      begin
         abort_run();
      end
   end

   // run limit of 20 clocks per command line
   initial
   begin
      wait (stim_lines != 0);
      #((stim_lines + 1) * 20 * CLK_PERIOD);
      $display("watchdog timeout, stimulus did not finish in time");
      abort_run();
   end

endmodule

// File: verification/centipede_io_stim.txt
# one command per line, all fields hex
# W addr data | R addr expect | T raw | P player joy sw1 sw2 vblank | L led coin | E
P 000 00 a5 3c 0
R 0800 a5
R 0801 3c
R 1000 00
W 1c03 80
W 1c04 80
W 1c05 80
W 1c06 80
W 1c04 00
L d 0
W 1c00 80
W 1c02 80
L d 5
R 0c01 a0
W 1c00 00
W 1c02 00
L d 0
P 0d6 5a a5 3c 1
R 0c03 5a
R 0c01 39
R 0c00 60
P 000 5a a5 3c 0
T 40
T 50
R 0c00 8f
T 40
T 50
R 0c00 80
T 00
T 10
R 0c00 01
T 00
T 10
T 00
T 10
R 0c00 0f
R 0c02 00
T 11
R 0c02 0f
W 2400 00
R 0c00 00
R 0c02 00
W 1c07 80
L d 0
T 19
T 1b
R 0c02 8f
T 19
T 1b
R 0c02 80
T 1a
T 1b
R 0c02 80
R 0c00 00
E

// File: src.f
hw/centipede_io_pkg.sv
hw/mpu_io_control.sv
hw/trakball_sync.sv
hw/trakball_axis.sv
hw/io_read_mux.sv
hw/centipede_io.sv
verification/tb_centipede_io.sv

// File: run_sim.sh
#!/bin/sh
# build and run the centipede i/o testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module tb_centipede_io -o tb_sim
out=$(./obj_dir/tb_sim 2>&1 || true)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "sim passed"
then
   exit 0
fi
exit 1
